// ==== source/lane_seq_settings.svh ====
////////////////////////////////////////////////////////////
// Machine sizes for one lane sequencer. The lane count must
// be a power of two so that the lane index splits the vl
////////////////////////////////////////////////////////////

`ifndef LANE_SEQ_SETTINGS_SVH
`define LANE_SEQ_SETTINGS_SVH

// Lanes in the whole machine and instruction IDs in flight
`define LANE_SEQ_NR_LANES 4
`define LANE_SEQ_NR_VINSN 8

// Vector length, start and register index widths
`define LANE_SEQ_VL_WIDTH 16
`define LANE_SEQ_VREG_WIDTH 5

// Operand command slots, and the register that holds the mask
`define LANE_SEQ_NR_OPQUEUES 6
`define LANE_SEQ_VMASK 0

`endif

// ==== source/lane_seq_pkg.sv ====
////////////////////////////////////////////////////////////
// Types shared by the lane sequencer and its testbench
////////////////////////////////////////////////////////////

`include "lane_seq_settings.svh"

package lane_seq_pkg;

  typedef logic [$clog2(`LANE_SEQ_NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(`LANE_SEQ_NR_LANES)-1:0] lane_id_t;
  typedef logic [`LANE_SEQ_VL_WIDTH-1:0]         vl_t;
  typedef logic [`LANE_SEQ_VREG_WIDTH-1:0]       vreg_t;

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vsew_e;

  typedef enum logic {VFU_ALU, VFU_MFPU} vfu_e;

  // ALU opcodes first, then the multiplier/FPU ones
  typedef enum logic [2:0] {
    VADD, VSUB, VAND, VOR, VXOR, VMUL, VMACC, VFADD
  } vinsn_op_e;

  // Slot index of each operand command queue
  typedef enum logic [2:0] {
    ALU_A, ALU_B, MFPU_A, MFPU_B, MFPU_C, MASK_M
  } opqueue_e;

  typedef struct packed {
    vid_t      id;
    vinsn_op_e op;
    vfu_e      vfu;
    logic      vm;
    vreg_t     vs1;
    vreg_t     vs2;
    vreg_t     vd;
    logic      use_vs1;
    logic      use_vs2;
    logic      use_vd_op;
    vl_t       vl;
    vl_t       vstart;
    vsew_e     vsew;
  } pe_req_t;

  // Same as the request, but vl and vstart are this lane's share
  typedef struct packed {
    vid_t      id;
    vinsn_op_e op;
    vfu_e      vfu;
    logic      vm;
    vreg_t     vs1;
    vreg_t     vs2;
    vreg_t     vd;
    logic      use_vs1;
    logic      use_vs2;
    logic      use_vd_op;
    vsew_e     vsew;
    vl_t       vl;
    vl_t       vstart;
  } vfu_operation_t;

  typedef struct packed {
    vid_t  id;
    vreg_t vs;
    vsew_e eew;
    vl_t   vl;
    vl_t   vstart;
  } operand_request_cmd_t;

  typedef struct packed {
    logic [`LANE_SEQ_NR_VINSN-1:0] vinsn_done;
  } pe_resp_t;

endpackage

// ==== source/request_intake.sv ====
////////////////////////////////////////////////////////////
// The main sequencer keeps valid high until all lanes take the
// instruction, so a repeated ID is masked until valid drops
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module request_intake import lane_seq_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  pe_req_t pe_req_i,
  input  logic    pe_req_valid_i,
  output logic    pe_req_ready_o,
  output pe_req_t held_req_o,
  output logic    held_valid_o,
  input  logic    held_pop_i
);

  vid_t    last_id_q;
  logic    sync_q;
  logic    valid_msk;
  logic    accept;
  pe_req_t reg_q;
  logic    full_q;

  ////////////////////////////////////////////////////////////
  // Broadcast deduplication
  ////////////////////////////////////////////////////////////

  // Mask the ID that was already taken while the broadcast lasts
  assign valid_msk = (sync_q && (pe_req_i.id == last_id_q)) ? 1'b0 : pe_req_valid_i;
  assign accept    = valid_msk && pe_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_id_q <= '0;
      sync_q    <= 1'b0;
    end else if (accept) begin
      last_id_q <= pe_req_i.id;
      sync_q    <= 1'b1;
    end else if (!pe_req_valid_i) begin
      sync_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // One-entry fall-through register
  ////////////////////////////////////////////////////////////

  // An empty register passes the input straight through
  assign held_valid_o   = full_q || valid_msk;
  assign held_req_o     = full_q ? reg_q : pe_req_i;
  assign pe_req_ready_o = !full_q || held_pop_i;

  // The register only fills when the taken request is not consumed at once
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= full_q || !held_pop_i;
    end else if (held_pop_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      reg_q <= pe_req_i;
    end
  end

  // A request waiting for the issue logic must not change under it
  held_req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    held_valid_o && !held_pop_i |=> $stable(held_req_o));

endmodule

// ==== source/operand_cmd_builder.sv ====
////////////////////////////////////////////////////////////
// Only ALU and MFPU requests are decoded here. The mask slot
// covers the whole vector, not only this lane's share
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lane_seq_settings.svh"

module operand_cmd_builder import lane_seq_pkg::*; (
  input  pe_req_t                                          held_req_i,
  input  vl_t                                              lane_vl_i,
  input  vl_t                                              lane_vstart_i,
  output operand_request_cmd_t [`LANE_SEQ_NR_OPQUEUES-1:0] cmd_o,
  output logic                 [`LANE_SEQ_NR_OPQUEUES-1:0] want_push_o,
  output logic                 [`LANE_SEQ_NR_OPQUEUES-1:0] uses_slot_o
);

  // Mask bits per register word across all lanes
  localparam int unsigned MASK_DIV = `LANE_SEQ_NR_LANES * 8;

  operand_request_cmd_t base_cmd;
  vl_t                  mask_vl;
  logic [31:0]          mask_cover;

  // Every slot starts from the lane share of the request
  assign base_cmd = '{
    id:     held_req_i.id,
    vs:     '0,
    eew:    held_req_i.vsew,
    vl:     lane_vl_i,
    vstart: lane_vstart_i
  };

  ////////////////////////////////////////////////////////////
  // Mask operand length
  ////////////////////////////////////////////////////////////

  // Round up so that the last partial mask word is still fetched
  always_comb begin
    mask_vl    = vl_t'(held_req_i.vl / MASK_DIV) >> held_req_i.vsew;
    mask_cover = (32'(mask_vl) << held_req_i.vsew) * MASK_DIV;
    if (mask_cover != 32'(held_req_i.vl)) begin
      mask_vl = mask_vl + vl_t'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Slot commands
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int q = 0; q < `LANE_SEQ_NR_OPQUEUES; q++) begin
      cmd_o[q] = base_cmd;
    end
    want_push_o = '0;
    uses_slot_o = '0;

    unique case (held_req_i.vfu)
      VFU_ALU: begin
        cmd_o[ALU_A].vs    = held_req_i.vs1;
        cmd_o[ALU_B].vs    = held_req_i.vs2;
        want_push_o[ALU_A] = held_req_i.use_vs1;
        want_push_o[ALU_B] = held_req_i.use_vs2;
        uses_slot_o[ALU_A] = 1'b1;
        uses_slot_o[ALU_B] = 1'b1;
      end
      VFU_MFPU: begin
        // The accumulator of a multiply-add comes from vd
        cmd_o[MFPU_A].vs    = held_req_i.vs1;
        cmd_o[MFPU_B].vs    = held_req_i.vs2;
        cmd_o[MFPU_C].vs    = held_req_i.vd;
        want_push_o[MFPU_A] = held_req_i.use_vs1;
        want_push_o[MFPU_B] = held_req_i.use_vs2;
        want_push_o[MFPU_C] = held_req_i.use_vd_op;
        uses_slot_o[MFPU_A] = 1'b1;
        uses_slot_o[MFPU_B] = 1'b1;
        uses_slot_o[MFPU_C] = 1'b1;
      end
      default: ;
    endcase

    // Both units read the mask when the instruction is masked
    cmd_o[MASK_M].vs    = vreg_t'(`LANE_SEQ_VMASK);
    cmd_o[MASK_M].vl    = mask_vl;
    want_push_o[MASK_M] = !held_req_i.vm;
    uses_slot_o[MASK_M] = 1'b1;
  end

endmodule

// ==== source/operand_cmd_slots.sv ====
////////////////////////////////////////////////////////////
// A push wins over a ready in the same cycle. Stored commands
// are kept after they are taken and only valid is cleared
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lane_seq_settings.svh"

module operand_cmd_slots import lane_seq_pkg::*; (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  operand_request_cmd_t [`LANE_SEQ_NR_OPQUEUES-1:0] cmd_i,
  input  logic                 [`LANE_SEQ_NR_OPQUEUES-1:0] want_push_i,
  input  logic                                             issue_fire_i,
  output operand_request_cmd_t [`LANE_SEQ_NR_OPQUEUES-1:0] operand_request_o,
  output logic                 [`LANE_SEQ_NR_OPQUEUES-1:0] operand_request_valid_o,
  input  logic                 [`LANE_SEQ_NR_OPQUEUES-1:0] operand_request_ready_i,
  output logic                 [`LANE_SEQ_NR_OPQUEUES-1:0] slot_busy_o
);

  logic [`LANE_SEQ_NR_OPQUEUES-1:0] push;

  assign push        = want_push_i & {`LANE_SEQ_NR_OPQUEUES{issue_fire_i}};
  assign slot_busy_o = operand_request_valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      operand_request_valid_o <= '0;
    end else begin
      for (int q = 0; q < `LANE_SEQ_NR_OPQUEUES; q++) begin
        if (push[q]) begin
          operand_request_valid_o[q] <= 1'b1;
        end else if (operand_request_ready_i[q]) begin
          operand_request_valid_o[q] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int q = 0; q < `LANE_SEQ_NR_OPQUEUES; q++) begin
      if (push[q]) begin
        operand_request_o[q] <= cmd_i[q];
      end
    end
  end

  // The issue logic must never overwrite a command still waiting
  no_push_on_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push & operand_request_valid_o & ~operand_request_ready_i) == '0);

endmodule

// ==== source/issue_control.sv ====
////////////////////////////////////////////////////////////
// The units have no ready. An ID still running when popped is
// dropped, and a zero lane share is reported done at once
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lane_seq_settings.svh"

module issue_control import lane_seq_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  lane_id_t                         lane_id_i,
  input  pe_req_t                          held_req_i,
  input  logic                             held_valid_i,
  output logic                             held_pop_o,
  input  logic [`LANE_SEQ_NR_OPQUEUES-1:0] uses_slot_i,
  input  logic [`LANE_SEQ_NR_OPQUEUES-1:0] slot_busy_i,
  output logic                             issue_fire_o,
  output vl_t                              lane_vl_o,
  output vl_t                              lane_vstart_o,
  input  logic [`LANE_SEQ_NR_VINSN-1:0]    pe_vinsn_running_i,
  output pe_resp_t                         pe_resp_o,
  output vfu_operation_t                   vfu_operation_o,
  output logic                             vfu_operation_valid_o,
  input  logic [`LANE_SEQ_NR_VINSN-1:0]    alu_vinsn_done_i,
  input  logic [`LANE_SEQ_NR_VINSN-1:0]    mfpu_vinsn_done_i,
  output logic                             alu_vinsn_done_o,
  output logic                             mfpu_vinsn_done_o
);

  localparam vl_t NR_LANES_VL = vl_t'(`LANE_SEQ_NR_LANES);

  logic [`LANE_SEQ_NR_VINSN-1:0] running_q, running_d;
  logic [`LANE_SEQ_NR_VINSN-1:0] done_q, done_d;
  logic                          extra_elem;
  logic                          op_valid_d;

  ////////////////////////////////////////////////////////////
  // Lane share of the vector
  ////////////////////////////////////////////////////////////

  // Low lanes take one more element when vl does not split evenly
  assign extra_elem    = lane_id_i < lane_id_t'(held_req_i.vl % NR_LANES_VL);
  assign lane_vl_o     = held_req_i.vl / NR_LANES_VL + vl_t'(extra_elem);
  assign lane_vstart_o = held_req_i.vstart / NR_LANES_VL;

  ////////////////////////////////////////////////////////////
  // Issue decision and ID tracking
  ////////////////////////////////////////////////////////////

  assign held_pop_o   = held_valid_i && ((uses_slot_i & slot_busy_i) == '0);
  assign issue_fire_o = held_pop_o && !(running_q[held_req_i.id] &&
                                        pe_vinsn_running_i[held_req_i.id]);

  always_comb begin
    running_d  = running_q & pe_vinsn_running_i;
    done_d     = alu_vinsn_done_i | mfpu_vinsn_done_i;
    op_valid_d = 1'b0;
    if (issue_fire_o) begin
      if (lane_vl_o == '0) begin
        // Nothing for this lane, so the instruction is muted
        done_d[held_req_i.id] = 1'b1;
      end else begin
        running_d[held_req_i.id] = 1'b1;
        op_valid_d               = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q             <= '0;
      done_q                <= '0;
      vfu_operation_valid_o <= 1'b0;
      alu_vinsn_done_o      <= 1'b0;
      mfpu_vinsn_done_o     <= 1'b0;
    end else begin
      running_q             <= running_d;
      done_q                <= done_d;
      vfu_operation_valid_o <= op_valid_d;
      alu_vinsn_done_o      <= |alu_vinsn_done_i;
      mfpu_vinsn_done_o     <= |mfpu_vinsn_done_i;
    end
  end

  assign pe_resp_o.vinsn_done = done_q;

  // Fields copied from the request, with the lane share in place of vl
  always_ff @(posedge clk_i) begin
    if (issue_fire_o) begin
      vfu_operation_o <= '{
        id:        held_req_i.id,
        op:        held_req_i.op,
        vfu:       held_req_i.vfu,
        vm:        held_req_i.vm,
        vs1:       held_req_i.vs1,
        vs2:       held_req_i.vs2,
        vd:        held_req_i.vd,
        use_vs1:   held_req_i.use_vs1,
        use_vs2:   held_req_i.use_vs2,
        use_vd_op: held_req_i.use_vd_op,
        vsew:      held_req_i.vsew,
        vl:        lane_vl_o,
        vstart:    lane_vstart_o
      };
    end
  end

  // A muted instruction must never reach a unit
  no_zero_vl_op_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    vfu_operation_valid_o |-> (vfu_operation_o.vl != '0));

endmodule

// ==== source/lane_sequencer.sv ====
////////////////////////////////////////////////////////////
// Lane sequencer for ALU and MFPU instructions only
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lane_seq_settings.svh"

module lane_sequencer import lane_seq_pkg::*; (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  lane_id_t                                         lane_id_i,
  // Main sequencer
  input  pe_req_t                                          pe_req_i,
  input  logic                                             pe_req_valid_i,
  output logic                                             pe_req_ready_o,
  input  logic                 [`LANE_SEQ_NR_VINSN-1:0]    pe_vinsn_running_i,
  output pe_resp_t                                         pe_resp_o,
  // Operand requester
  output operand_request_cmd_t [`LANE_SEQ_NR_OPQUEUES-1:0] operand_request_o,
  output logic                 [`LANE_SEQ_NR_OPQUEUES-1:0] operand_request_valid_o,
  input  logic                 [`LANE_SEQ_NR_OPQUEUES-1:0] operand_request_ready_i,
  // Lane units
  output vfu_operation_t                                   vfu_operation_o,
  output logic                                             vfu_operation_valid_o,
  input  logic                 [`LANE_SEQ_NR_VINSN-1:0]    alu_vinsn_done_i,
  input  logic                 [`LANE_SEQ_NR_VINSN-1:0]    mfpu_vinsn_done_i,
  output logic                                             alu_vinsn_done_o,
  output logic                                             mfpu_vinsn_done_o
);

  pe_req_t                                          held_req;
  logic                                             held_valid;
  logic                                             held_pop;
  logic                                             issue_fire;
  vl_t                                              lane_vl;
  vl_t                                              lane_vstart;
  operand_request_cmd_t [`LANE_SEQ_NR_OPQUEUES-1:0] cmd;
  logic                 [`LANE_SEQ_NR_OPQUEUES-1:0] want_push;
  logic                 [`LANE_SEQ_NR_OPQUEUES-1:0] uses_slot;
  logic                 [`LANE_SEQ_NR_OPQUEUES-1:0] slot_busy;

  request_intake u_request_intake (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_ready_o (pe_req_ready_o),
    .held_req_o     (held_req),
    .held_valid_o   (held_valid),
    .held_pop_i     (held_pop)
  );

  operand_cmd_builder u_operand_cmd_builder (
    .held_req_i    (held_req),
    .lane_vl_i     (lane_vl),
    .lane_vstart_i (lane_vstart),
    .cmd_o         (cmd),
    .want_push_o   (want_push),
    .uses_slot_o   (uses_slot)
  );

  operand_cmd_slots u_operand_cmd_slots (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .cmd_i                   (cmd),
    .want_push_i             (want_push),
    .issue_fire_i            (issue_fire),
    .operand_request_o       (operand_request_o),
    .operand_request_valid_o (operand_request_valid_o),
    .operand_request_ready_i (operand_request_ready_i),
    .slot_busy_o             (slot_busy)
  );

  issue_control u_issue_control (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .lane_id_i             (lane_id_i),
    .held_req_i            (held_req),
    .held_valid_i          (held_valid),
    .held_pop_o            (held_pop),
    .uses_slot_i           (uses_slot),
    .slot_busy_i           (slot_busy),
    .issue_fire_o          (issue_fire),
    .lane_vl_o             (lane_vl),
    .lane_vstart_o         (lane_vstart),
    .pe_vinsn_running_i    (pe_vinsn_running_i),
    .pe_resp_o             (pe_resp_o),
    .vfu_operation_o       (vfu_operation_o),
    .vfu_operation_valid_o (vfu_operation_valid_o),
    .alu_vinsn_done_i      (alu_vinsn_done_i),
    .mfpu_vinsn_done_i     (mfpu_vinsn_done_i),
    .alu_vinsn_done_o      (alu_vinsn_done_o),
    .mfpu_vinsn_done_o     (mfpu_vinsn_done_o)
  );

endmodule

// ==== testbench/tb_lane_sequencer.sv ====
////////////////////////////////////////////////////////////
// Runs the instructions of lane_seq_patterns.txt one by one
// from the project root. One global stall holds all ready bits
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lane_seq_settings.svh"

module tb_lane_sequencer import lane_seq_pkg::*; ();

  localparam int NUM_PAT  = 16;
  localparam int NUM_COLS = 18;
  localparam int NQ       = `LANE_SEQ_NR_OPQUEUES;
  localparam int NV       = `LANE_SEQ_NR_VINSN;
  localparam int LANES    = `LANE_SEQ_NR_LANES;

  logic                           clk_i;
  logic                           rst_ni;
  lane_id_t                       lane_id_i;
  pe_req_t                        pe_req_i;
  logic                           pe_req_valid_i;
  logic                           pe_req_ready_o;
  logic                 [NV-1:0]  pe_vinsn_running_i;
  pe_resp_t                       pe_resp_o;
  operand_request_cmd_t [NQ-1:0]  operand_request_o;
  logic                 [NQ-1:0]  operand_request_valid_o;
  logic                 [NQ-1:0]  operand_request_ready_i;
  vfu_operation_t                 vfu_operation_o;
  logic                           vfu_operation_valid_o;
  logic                 [NV-1:0]  alu_vinsn_done_i;
  logic                 [NV-1:0]  mfpu_vinsn_done_i;
  logic                           alu_vinsn_done_o;
  logic                           mfpu_vinsn_done_o;

  logic [15:0] pat_mem [0:NUM_PAT*NUM_COLS-1];

  // Values applied to the DUT at the next rising edge
  pe_req_t              drv_req;
  logic                 drv_valid;
  lane_id_t             drv_lane;
  logic [NV-1:0]        drv_running;
  logic [NV-1:0]        drv_alu_done;
  logic [NV-1:0]        drv_mfpu_done;
  int                   stall_left;
  int                   seed = 32'hacc1_906b;

  // Expectations of the instruction in progress
  pe_req_t              cur_req;
  vfu_operation_t       exp_op;
  operand_request_cmd_t exp_cmd [NQ];
  logic [NQ-1:0]        exp_push;
  logic [NQ-1:0]        exp_uses;
  logic                 exp_muted;
  pe_resp_t             exp_done_resp;
  logic                 issued;
  operand_request_cmd_t saved_cmd [NQ];
  logic [NQ-1:0]        pending;
  // The request sits in the intake register while its slots are busy
  logic                 held_full;

  lane_sequencer UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_vfu_operation(input vfu_operation_t got, input vfu_operation_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch vfu_operation_o: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_operand_cmd(input int q, input operand_request_cmd_t got,
                                   input operand_request_cmd_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch operand_request_o[%0d]: got %h expected %h",
                              q, got, exp));
    end
  endtask

  task automatic check_resp(input pe_resp_t got, input pe_resp_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch pe_resp_o: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic vl_t model_lane_vl(input lane_id_t lane, input vl_t vl);
    int v;
    v = int'(vl);
    return vl_t'(v / LANES + ((int'(lane) < v % LANES) ? 1 : 0));
  endfunction

  // Mask bits are packed across all lanes, 8 per byte and element width
  function automatic vl_t model_mask_vl(input vl_t vl, input vsew_e sew);
    int v;
    int per_word;
    int words;
    v        = int'(vl);
    per_word = (8 * LANES) << int'(sew);
    words    = v / per_word;
    if (words * per_word != v) begin
      words++;
    end
    return vl_t'(words);
  endfunction

  task automatic load_pattern(input int p);
    int       b;
    int       stall;
    vl_t      lvl;
    vl_t      lvs;
    vl_t      mvl;
    b = p * NUM_COLS;
    drv_lane         = lane_id_t'(pat_mem[b][1:0]);
    cur_req.id       = vid_t'(pat_mem[b+1][2:0]);
    cur_req.op       = vinsn_op_e'(pat_mem[b+2][2:0]);
    cur_req.vfu      = vfu_e'(pat_mem[b+3][0]);
    cur_req.vm       = pat_mem[b+4][0];
    cur_req.vs1      = vreg_t'(pat_mem[b+5][4:0]);
    cur_req.vs2      = vreg_t'(pat_mem[b+6][4:0]);
    cur_req.vd       = vreg_t'(pat_mem[b+7][4:0]);
    cur_req.use_vs1  = pat_mem[b+8][0];
    cur_req.use_vs2  = pat_mem[b+9][0];
    cur_req.use_vd_op = pat_mem[b+10][0];
    cur_req.vl       = pat_mem[b+11];
    cur_req.vstart   = pat_mem[b+12];
    cur_req.vsew     = vsew_e'(pat_mem[b+13][1:0]);
    lvl = model_lane_vl(drv_lane, cur_req.vl);
    lvs = vl_t'(int'(cur_req.vstart) / LANES);
    mvl = model_mask_vl(cur_req.vl, cur_req.vsew);
    if (lvl != pat_mem[b+15] || lvs != pat_mem[b+16] || mvl != pat_mem[b+17]) begin
      stop_on_error($sformatf("Pattern %0d disagrees with the lane share model", p));
    end
    stall = int'(pat_mem[b+14]) + ($random(seed) & 3);
    if (stall_left < stall) begin
      stall_left = stall;
    end
    held_full = 1'b0;

    exp_op = '{id: cur_req.id, op: cur_req.op, vfu: cur_req.vfu, vm: cur_req.vm,
               vs1: cur_req.vs1, vs2: cur_req.vs2, vd: cur_req.vd,
               use_vs1: cur_req.use_vs1, use_vs2: cur_req.use_vs2,
               use_vd_op: cur_req.use_vd_op, vsew: cur_req.vsew, vl: lvl, vstart: lvs};
    exp_muted = (lvl == '0);
    exp_done_resp = '0;
    exp_done_resp.vinsn_done[cur_req.id] = 1'b1;
    for (int q = 0; q < NQ; q++) begin
      exp_cmd[q] = '{id: cur_req.id, vs: '0, eew: cur_req.vsew, vl: lvl, vstart: lvs};
    end
    exp_push = '0;
    exp_uses = '0;
    if (cur_req.vfu == VFU_ALU) begin
      exp_cmd[ALU_A].vs = cur_req.vs1;
      exp_cmd[ALU_B].vs = cur_req.vs2;
      exp_push[ALU_A]   = cur_req.use_vs1;
      exp_push[ALU_B]   = cur_req.use_vs2;
      exp_uses[ALU_A]   = 1'b1;
      exp_uses[ALU_B]   = 1'b1;
    end else begin
      exp_cmd[MFPU_A].vs = cur_req.vs1;
      exp_cmd[MFPU_B].vs = cur_req.vs2;
      exp_cmd[MFPU_C].vs = cur_req.vd;
      exp_push[MFPU_A]   = cur_req.use_vs1;
      exp_push[MFPU_B]   = cur_req.use_vs2;
      exp_push[MFPU_C]   = cur_req.use_vd_op;
      exp_uses[MFPU_A]   = 1'b1;
      exp_uses[MFPU_B]   = 1'b1;
      exp_uses[MFPU_C]   = 1'b1;
    end
    exp_cmd[MASK_M].vs = vreg_t'(`LANE_SEQ_VMASK);
    exp_cmd[MASK_M].vl = mvl;
    exp_push[MASK_M]   = !cur_req.vm;
    exp_uses[MASK_M]   = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // Cycle driver and monitor
  ////////////////////////////////////////////////////////////

  task automatic sample_cycle();
    logic pop_exp;
    // The waiting request pops in the cycle where none of its slots is valid
    pop_exp = ((pending & exp_uses) == '0);
    if (!issued && !vfu_operation_valid_o && pe_resp_o.vinsn_done == '0) begin
      check_flag("pe_req_ready_o", pe_req_ready_o, !held_full || pop_exp);
      held_full = !pop_exp;
    end else begin
      check_flag("pe_req_ready_o", pe_req_ready_o, 1'b1);
    end
    if (!issued && (vfu_operation_valid_o || pe_resp_o.vinsn_done != '0)) begin
      issued = 1'b1;
      if (exp_muted) begin
        if (vfu_operation_valid_o) begin
          stop_on_error("A muted instruction was issued to a unit");
        end
        check_resp(pe_resp_o, exp_done_resp);
      end else begin
        check_vfu_operation(vfu_operation_o, exp_op);
        check_resp(pe_resp_o, pe_resp_t'('0));
      end
      for (int q = 0; q < NQ; q++) begin
        if (exp_push[q]) begin
          if (pending[q]) begin
            stop_on_error($sformatf("Slot %0d was overwritten before it was taken", q));
          end
          if (!operand_request_valid_o[q]) begin
            stop_on_error($sformatf("Slot %0d was not pushed at issue", q));
          end
          check_operand_cmd(q, operand_request_o[q], exp_cmd[q]);
          saved_cmd[q] = exp_cmd[q];
          pending[q]   = 1'b1;
        end else if (exp_uses[q] && operand_request_valid_o[q]) begin
          stop_on_error($sformatf("Slot %0d became valid without a push", q));
        end
      end
    end else if (vfu_operation_valid_o) begin
      stop_on_error("The VFU was issued a second time for one broadcast");
    end
    for (int q = 0; q < NQ; q++) begin
      if (pending[q] && !operand_request_valid_o[q]) begin
        stop_on_error($sformatf("Slot %0d dropped its command before ready", q));
      end
      if (operand_request_valid_o[q]) begin
        check_operand_cmd(q, operand_request_o[q], saved_cmd[q]);
      end
    end
    // The ready seen now is the one the DUT samples at the next edge
    pending = pending & ~operand_request_ready_i;
  endtask

  task automatic step();
    @(posedge clk_i);
    pe_req_i           <= drv_req;
    pe_req_valid_i     <= drv_valid;
    lane_id_i          <= drv_lane;
    pe_vinsn_running_i <= drv_running;
    alu_vinsn_done_i   <= drv_alu_done;
    mfpu_vinsn_done_i  <= drv_mfpu_done;
    if (stall_left > 0) begin
      operand_request_ready_i <= {NQ{1'b0}};
      stall_left--;
    end else begin
      operand_request_ready_i <= {NQ{1'b1}};
    end
    @(negedge clk_i);
    sample_cycle();
  endtask

  initial begin
    repeat (NUM_PAT * 64 + 20) @(posedge clk_i);
    stop_on_error("Watchdog expired before all patterns finished");
  end

  initial begin
    rst_ni                  = 1'b0;
    lane_id_i               = '0;
    pe_req_i                = '0;
    pe_req_valid_i          = 1'b0;
    pe_vinsn_running_i      = '0;
    operand_request_ready_i = '0;
    alu_vinsn_done_i        = '0;
    mfpu_vinsn_done_i       = '0;
    drv_req       = '0;
    drv_valid     = 1'b0;
    drv_lane      = '0;
    drv_running   = '0;
    drv_alu_done  = '0;
    drv_mfpu_done = '0;
    stall_left    = 0;
    issued        = 1'b1;
    pending       = '0;
    held_full     = 1'b0;
    exp_uses      = '0;
    for (int q = 0; q < NQ; q++) begin
      saved_cmd[q] = '0;
    end
    $readmemh("testbench/lane_seq_patterns.txt", pat_mem);
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int p = 0; p < NUM_PAT; p++) begin
      load_pattern(p);
      drv_req     = cur_req;
      drv_valid   = 1'b1;
      drv_running[cur_req.id] = 1'b1;
      issued      = 1'b0;
      while (!issued) begin
        step();
      end
      // Valid stays high with the same ID, which must not issue again
      repeat (3) begin
        step();
        check_resp(pe_resp_o, pe_resp_t'('0));
      end
      drv_valid = 1'b0;
      step();
      check_resp(pe_resp_o, pe_resp_t'('0));
      drv_running[cur_req.id] = 1'b0;
      if (!exp_muted) begin
        if (cur_req.vfu == VFU_ALU) begin
          drv_alu_done[cur_req.id] = 1'b1;
        end else begin
          drv_mfpu_done[cur_req.id] = 1'b1;
        end
        step();
        drv_alu_done  = '0;
        drv_mfpu_done = '0;
        step();
        check_flag("alu_vinsn_done_o", alu_vinsn_done_o, cur_req.vfu == VFU_ALU);
        check_flag("mfpu_vinsn_done_o", mfpu_vinsn_done_o, cur_req.vfu == VFU_MFPU);
        check_resp(pe_resp_o, exp_done_resp);
      end
    end
    repeat (4) step();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== testbench/lane_seq_patterns.txt ====
// lane id op vfu vm vs1 vs2 vd use_vs1 use_vs2 use_vd vl vstart vsew stall
// then expected lane_vl lane_vstart mask_vl, all in hex
0 1 0 0 1 02 03 04 1 1 0 0040 0000 0 0 0010 0000 0002
1 2 5 1 0 05 06 07 1 1 0 0025 0008 1 3 0009 0002 0001
2 3 6 1 0 08 09 0a 1 1 1 0100 0010 2 a 0040 0004 0002
3 4 1 0 0 01 02 03 1 0 0 0003 0000 0 0 0000 0000 0001
0 4 1 0 0 01 02 03 1 0 0 0003 0000 0 2 0001 0000 0001
1 5 2 0 1 0b 0c 00 1 1 0 07ff 0021 3 c 0200 0008 0008
2 6 7 1 1 0d 0e 0f 1 1 0 0011 0000 2 0 0004 0000 0001
3 7 3 0 0 10 11 12 1 1 0 0040 0004 0 1 0010 0001 0002
0 0 4 0 1 13 14 00 0 1 0 0000 0000 0 0 0000 0000 0000
1 1 6 1 0 15 16 17 0 1 1 0081 0040 3 4 0020 0010 0001
2 2 0 0 1 18 19 1a 1 1 0 0006 0002 1 0 0001 0000 0001
3 3 5 1 1 1b 1c 1d 1 0 0 0007 0000 0 6 0001 0000 0001
1 3 1 0 0 1e 1f 01 1 1 0 0020 0000 0 0 0008 0000 0001
2 5 5 1 0 02 04 06 1 1 0 0003 0000 2 0 0001 0000 0001
3 6 7 1 1 01 01 01 1 1 1 0002 0000 0 0 0000 0000 0001
0 7 0 0 0 03 05 00 1 1 0 ffff fffc 3 8 4000 3fff 0100

// ==== build.f ====
+incdir+source
source/lane_seq_pkg.sv
source/request_intake.sv
source/operand_cmd_builder.sv
source/operand_cmd_slots.sv
source/issue_control.sv
source/lane_sequencer.sv
testbench/tb_lane_sequencer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the lane sequencer testbench from the project root.
# The exit status is the simulator's, so a $fatal gives a failing status.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f \
  --top-module tb_lane_sequencer -o sim_lane_sequencer &&
./obj_dir/sim_lane_sequencer || {
  echo "lane sequencer simulation did not pass"
  exit 1
}
